// File: include/klClk_cfg.svh
`ifndef KLCLK_CFG_SVH
`define KLCLK_CFG_SVH

// Width of one EBUS data word and of the EBUS load register
`define KL_EBUS_WIDTH 36

// Diagnostic function code
// Upper 4 bits select the group, lower 3 bits the function in it
`define KL_FUNC_WIDTH 7

// Burst counter, loaded as two 4-bit halves
`define KL_BURST_WIDTH 8

// Cycles the crowbar stays up after power-on reset is released
`define KL_CROBAR_CYCLES 50

// Flops in the diagnostic strobe synchronizer
`define KL_SYNC_STAGES 2

`endif

// File: src/klClkPkg.sv
`include "klClk_cfg.svh"

package klClkPkg;

  // Diagnostic function codes handled by the clock-control slice
  // Values are octal, as in the front-end listings
  typedef enum logic [`KL_FUNC_WIDTH-1:0] {
    // Clock run control, group 00
    funcStop         = 'o000,
    funcStart        = 'o001,
    funcStep         = 'o002,
    funcBurst        = 'o003,
    // EBOX reset flop
    funcClrReset     = 'o006,
    funcSetReset     = 'o007,
    // Burst counter halves, group 04
    funcLdBurstRight = 'o042,
    funcLdBurstLeft  = 'o043,
    // Clock source and rate
    funcLdSrcRate    = 'o044,
    // KL opcode enable, group 06
    funcKlOpcodes    = 'o067,
    // EBUS load register, group 07
    funcEbusLoad     = 'o076
  } diagFuncE;

  // Clock rate select
  // EBOX clock enable fires once per 2**rateSel master clocks
  typedef logic [1:0] rateSelT;

  // Clock source select, held as a control register only
  typedef logic [1:0] sourceSelT;

endpackage

// File: src/crobarSequencer.sv
`timescale 1ns/1ps
`include "klClk_cfg.svh"

module crobarSequencer (
  input  logic masterClk,
  input  logic arstN,
  output logic crobar
);

  // Enough bits to hold the full crowbar length
  localparam int countWidth = $clog2(`KL_CROBAR_CYCLES + 1);

  logic [countWidth-1:0] crobarCount;

  // Count loads on power-on reset and runs down to zero
  // Sticks at zero until the next power-on reset
  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      crobarCount <= countWidth'(`KL_CROBAR_CYCLES);
    end else if (crobarCount != '0) begin
      crobarCount <= crobarCount - 1'b1;
    end
  end

  // Crowbar holds while any count remains
  // Falls right after the last of the KL_CROBAR_CYCLES edges
  assign crobar = (crobarCount != '0);

endmodule

// File: src/diagFuncDecoder.sv
`timescale 1ns/1ps
`include "klClk_cfg.svh"

module diagFuncDecoder (
  input  logic                      masterClk,
  input  logic                      arstN,
  input  logic                      crobar,
  input  logic                      diagStrobe,
  input  logic [`KL_FUNC_WIDTH-1:0] diagFunc,
  input  logic [`KL_EBUS_WIDTH-1:0] ebusData,
  output logic                      funcValid,
  output klClkPkg::diagFuncE        funcCode,
  output logic [`KL_EBUS_WIDTH-1:0] funcData
);

  localparam int syncStages = `KL_SYNC_STAGES;

  // Strobe synchronizer
  // Bit 0 samples the front end
  logic [syncStages-1:0] strobeSync;
  // Synchronized strobe delayed a cycle for edge detect
  logic strobeDly;
  logic strobeRise;
  // Set on the cycle the code and data were captured
  logic captureDone;

  // Front-end strobe is asynchronous to masterClk
  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      strobeSync <= '0;
      strobeDly  <= 1'b0;
    end else begin
      strobeSync <= {strobeSync[syncStages-2:0], diagStrobe};
      strobeDly  <= strobeSync[syncStages-1];
    end
  end

  assign strobeRise = strobeSync[syncStages-1] & ~strobeDly;

  // Functions strobed during power-on are dropped here
  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      captureDone <= 1'b0;
      funcValid   <= 1'b0;
    end else begin
      captureDone <= strobeRise & ~crobar;
      // Valid follows capture by a cycle so code and data are settled
      funcValid   <= captureDone;
    end
  end

  // Front end holds code and data stable while the strobe is high
  // Safe to take them at the synchronized edge
  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      funcCode <= klClkPkg::funcStop;
      funcData <= '0;
    end else if (strobeRise && !crobar) begin
      funcCode <= klClkPkg::diagFuncE'(diagFunc);
      funcData <= ebusData;
    end
  end

endmodule

// File: src/clkControl.sv
`timescale 1ns/1ps
`include "klClk_cfg.svh"

module clkControl (
  input  logic                       masterClk,
  input  logic                       arstN,
  input  logic                       crobar,
  input  logic                       funcValid,
  input  klClkPkg::diagFuncE         funcCode,
  input  logic [`KL_EBUS_WIDTH-1:0]  funcData,
  output logic                       eboxReset,
  output logic                       running,
  output logic                       eboxClkEn,
  output logic                       klOpcodesEn,
  output klClkPkg::sourceSelT        sourceSel,
  output klClkPkg::rateSelT          rateSel,
  output logic [`KL_BURST_WIDTH-1:0] burstCount,
  output logic [`KL_EBUS_WIDTH-1:0]  ebusReg
);

  // Each burst counter half is loaded separately
  localparam int halfWidth = `KL_BURST_WIDTH / 2;

  logic resetFlop;

  // Rate divider, wide enough for the slowest rate of 8 clocks
  logic [2:0] divCount;
  logic [2:0] rateMask;
  logic       divWrap;

  // Single step and burst bookkeeping
  logic                       stepPending;
  logic [`KL_BURST_WIDTH-1:0] burstRemain;
  logic                       burstActive;
  logic                       clkFire;
  // Start, step or burst restarts the divider phase
  logic                       modeRestart;

  // Crowbar forces EBOX reset regardless of the flop
  assign eboxReset = resetFlop | crobar;

  // Low rateSel bits of the divider all ones marks a period end
  assign rateMask = 3'((4'd1 << rateSel) - 4'd1);
  assign divWrap  = ((divCount & rateMask) == rateMask);

  assign burstActive = (burstRemain != '0);
  assign clkFire     = divWrap & (running | stepPending | burstActive);

  assign modeRestart = funcValid &&
                       (funcCode == klClkPkg::funcStart ||
                        funcCode == klClkPkg::funcStep  ||
                        funcCode == klClkPkg::funcBurst);

  // Free-running divider
  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      divCount <= '0;
    end else if (modeRestart) begin
      divCount <= '0;
    end else begin
      divCount <= divCount + 1'b1;
    end
  end

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      resetFlop   <= 1'b0;
      running     <= 1'b0;
      eboxClkEn   <= 1'b0;
      klOpcodesEn <= 1'b0;
      sourceSel   <= '0;
      rateSel     <= '0;
      burstCount  <= '0;
      ebusReg     <= '0;
      stepPending <= 1'b0;
      burstRemain <= '0;
    end else begin
      eboxClkEn <= clkFire;

      // Each enable pulse uses up a pending step or one burst count
      // Free running consumes nothing
      if (clkFire && !running) begin
        if (stepPending) begin
          stepPending <= 1'b0;
        end else if (burstActive) begin
          burstRemain <= burstRemain - 1'b1;
        end
      end

      // Function execution comes last so it wins over consumption
      if (funcValid) begin
        case (funcCode)
          klClkPkg::funcStop: begin
            running     <= 1'b0;
            stepPending <= 1'b0;
            burstRemain <= '0;
          end
          klClkPkg::funcStart: begin
            running     <= 1'b1;
            stepPending <= 1'b0;
            burstRemain <= '0;
          end
          klClkPkg::funcStep: begin
            running     <= 1'b0;
            stepPending <= 1'b1;
            burstRemain <= '0;
          end
          // Burst runs off a copy so burstCount stays readable
          klClkPkg::funcBurst: begin
            running     <= 1'b0;
            stepPending <= 1'b0;
            burstRemain <= burstCount;
          end
          klClkPkg::funcClrReset: resetFlop <= 1'b0;
          klClkPkg::funcSetReset: resetFlop <= 1'b1;
          klClkPkg::funcLdBurstRight: begin
            burstCount[halfWidth-1:0] <= funcData[halfWidth-1:0];
          end
          klClkPkg::funcLdBurstLeft: begin
            burstCount[`KL_BURST_WIDTH-1:halfWidth] <= funcData[halfWidth-1:0];
          end
          // Source in bits 1:0, rate in bits 3:2
          klClkPkg::funcLdSrcRate: begin
            sourceSel <= klClkPkg::sourceSelT'(funcData[1:0]);
            rateSel   <= klClkPkg::rateSelT'(funcData[3:2]);
          end
          klClkPkg::funcKlOpcodes: klOpcodesEn <= 1'b1;
          klClkPkg::funcEbusLoad:  ebusReg     <= funcData;
          // Codes outside this slice are accepted and ignored
          default: ;
        endcase
      end
    end
  end

endmodule

// File: src/klClkTop.sv
`timescale 1ns/1ps
`include "klClk_cfg.svh"

module klClkTop (
  input  logic                       masterClk,
  input  logic                       arstN,
  input  logic                       diagStrobe,
  input  logic [`KL_FUNC_WIDTH-1:0]  diagFunc,
  input  logic [`KL_EBUS_WIDTH-1:0]  ebusData,
  output logic                       crobar,
  output logic                       eboxReset,
  output logic                       running,
  output logic                       eboxClkEn,
  output logic                       klOpcodesEn,
  output klClkPkg::sourceSelT        sourceSel,
  output klClkPkg::rateSelT          rateSel,
  output logic [`KL_BURST_WIDTH-1:0] burstCount,
  output logic [`KL_EBUS_WIDTH-1:0]  ebusReg
);

  // Decoded function from the diagnostic bus
  logic                      funcValid;
  klClkPkg::diagFuncE        funcCode;
  logic [`KL_EBUS_WIDTH-1:0] funcData;

  // Power-on crowbar
  crobarSequencer i_crobarSequencer (
    .masterClk (masterClk),
    .arstN     (arstN),
    .crobar    (crobar)
  );

  // Front-end diagnostic function bus
  diagFuncDecoder i_diagFuncDecoder (
    .masterClk  (masterClk),
    .arstN      (arstN),
    .crobar     (crobar),
    .diagStrobe (diagStrobe),
    .diagFunc   (diagFunc),
    .ebusData   (ebusData),
    .funcValid  (funcValid),
    .funcCode   (funcCode),
    .funcData   (funcData)
  );

  // Clock-control registers and EBOX clock enable
  clkControl i_clkControl (
    .masterClk   (masterClk),
    .arstN       (arstN),
    .crobar      (crobar),
    .funcValid   (funcValid),
    .funcCode    (funcCode),
    .funcData    (funcData),
    .eboxReset   (eboxReset),
    .running     (running),
    .eboxClkEn   (eboxClkEn),
    .klOpcodesEn (klOpcodesEn),
    .sourceSel   (sourceSel),
    .rateSel     (rateSel),
    .burstCount  (burstCount),
    .ebusReg     (ebusReg)
  );

endmodule

// File: verification/klClkTb.sv
`timescale 1ns/1ps
`include "klClk_cfg.svh"

module klClkTb;

  // Pulse window after each function
  // Long enough for the slowest rate
  localparam int windowCycles  = 64;
  localparam int resultTimeout = 32;

  logic                       masterClk;
  logic                       arstN;
  logic                       diagStrobe;
  logic [`KL_FUNC_WIDTH-1:0]  diagFunc;
  logic [`KL_EBUS_WIDTH-1:0]  ebusData;
  logic                       crobar;
  logic                       eboxReset;
  logic                       running;
  logic                       eboxClkEn;
  logic                       klOpcodesEn;
  klClkPkg::sourceSelT        sourceSel;
  klClkPkg::rateSelT          rateSel;
  logic [`KL_BURST_WIDTH-1:0] burstCount;
  logic [`KL_EBUS_WIDTH-1:0]  ebusReg;

  // Expected load registers from the field rules
  logic [`KL_BURST_WIDTH-1:0] burstModel;
  logic [1:0]                 srcModel;
  logic [1:0]                 rateModel;
  // Total enable pulses seen so far
  int pulseTotal;

  klClkTop i_klClkTop (
    .masterClk   (masterClk),
    .arstN       (arstN),
    .diagStrobe  (diagStrobe),
    .diagFunc    (diagFunc),
    .ebusData    (ebusData),
    .crobar      (crobar),
    .eboxReset   (eboxReset),
    .running     (running),
    .eboxClkEn   (eboxClkEn),
    .klOpcodesEn (klOpcodesEn),
    .sourceSel   (sourceSel),
    .rateSel     (rateSel),
    .burstCount  (burstCount),
    .ebusReg     (ebusReg)
  );

  initial begin
    masterClk = 1'b0;
    forever #10 masterClk = ~masterClk;
  end

  // Enable is sampled mid-cycle where it is settled
  always @(negedge masterClk) begin
    if (eboxClkEn === 1'b1) begin
      pulseTotal = pulseTotal + 1;
    end
  end

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    assert (actual === expected) else begin
      reportFailure($sformatf("Fail %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // Free-running counts may be off by one at the window edges
  task automatic compareNear(input string name, input int expected, input int actual);
    assert (actual - expected <= 1 && expected - actual <= 1) else begin
      reportFailure($sformatf("Fail %s expected %0h actual %0h within one",
                              name, expected, actual));
    end
  endtask

  // Crowbar length with EBOX reset held and strobes ignored
  task automatic powerOnCheck();
    int  edges;
    logic released;
    edges    = 0;
    released = 1'b0;
    for (int t = 0; t < 2 * `KL_CROBAR_CYCLES && !released; t++) begin
      @(posedge masterClk);
      edges++;
      // Function strobed in the middle of power-on
      if (edges == 2) begin
        diagFunc   <= klClkPkg::funcKlOpcodes;
        diagStrobe <= 1'b1;
      end
      if (edges == 6) begin
        diagStrobe <= 1'b0;
      end
      @(negedge masterClk);
      if (crobar !== 1'b1) begin
        released = 1'b1;
      end else begin
        checkValue("eboxReset", 1, eboxReset);
      end
    end
    assert (released) else reportFailure("Crowbar did not fall after power-on reset");
    checkValue("crobar release edges", `KL_CROBAR_CYCLES, edges);
    checkValue("eboxReset", 0, eboxReset);
    checkValue("klOpcodesEn", 0, klOpcodesEn);
    checkValue("running", 0, running);
    checkValue("sourceSel", 0, sourceSel);
    checkValue("rateSel", 0, rateSel);
    checkValue("burstCount", 0, burstCount);
    checkValue("ebusReg", 0, ebusReg);
  endtask

  // One front-end function followed by a poll for the expected state
  task automatic issueFunc(input logic [`KL_FUNC_WIDTH-1:0] func,
                           input logic [`KL_EBUS_WIDTH-1:0] data,
                           input logic expKl, input logic expRst, input logic expRun,
                           input logic [`KL_EBUS_WIDTH-1:0] expEbus,
                           output int preCount);
    int   preStart;
    logic matched;
    @(posedge masterClk);
    preStart   = pulseTotal;
    diagFunc   <= func;
    ebusData   <= data;
    diagStrobe <= 1'b1;
    repeat (4) @(posedge masterClk);
    diagStrobe <= 1'b0;
    repeat (4) @(posedge masterClk);
    // Field rules of the load functions
    if (func == klClkPkg::funcLdBurstRight) burstModel[3:0] = data[3:0];
    if (func == klClkPkg::funcLdBurstLeft) burstModel[7:4] = data[3:0];
    if (func == klClkPkg::funcLdSrcRate) begin
      srcModel  = data[1:0];
      rateModel = data[3:2];
    end
    matched = 1'b0;
    for (int t = 0; t < resultTimeout && !matched; t++) begin
      @(negedge masterClk);
      matched = klOpcodesEn === expKl && eboxReset === expRst && running === expRun &&
                ebusReg === expEbus && burstCount === burstModel &&
                sourceSel === srcModel && rateSel === rateModel;
    end
    checkValue("klOpcodesEn", expKl, klOpcodesEn);
    checkValue("eboxReset", expRst, eboxReset);
    checkValue("running", expRun, running);
    checkValue("ebusReg", expEbus, ebusReg);
    checkValue("burstCount", burstModel, burstCount);
    checkValue("sourceSel", srcModel, sourceSel);
    checkValue("rateSel", rateModel, rateSel);
    @(posedge masterClk);
    preCount = pulseTotal - preStart;
  endtask

  initial begin
    int                        fd;
    int                        fields;
    int                        records;
    int                        preCount;
    int                        postStart;
    int                        postCount;
    int                        seedDraw;
    int                        expCount;
    string                     line;
    logic                      wasRunning;
    logic [`KL_FUNC_WIDTH-1:0] func;
    logic [`KL_EBUS_WIDTH-1:0] data;
    logic                      expKl;
    logic                      expRst;
    logic                      expRun;
    logic [`KL_EBUS_WIDTH-1:0] expEbus;
    arstN      = 1'b0;
    diagStrobe = 1'b0;
    diagFunc   = '0;
    ebusData   = '0;
    pulseTotal = 0;
    burstModel = '0;
    srcModel   = '0;
    rateModel  = '0;
    wasRunning = 1'b0;
    records    = 0;
    seedDraw   = $urandom(84501);
    repeat (3) @(posedge masterClk);
    arstN <= 1'b1;
    powerOnCheck();
    fd = $fopen("verification/klClk_patterns.hex", "r");
    assert (fd != 0) else reportFailure("Could not open the pattern file");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h",
                         func, data, expKl, expRst, expRun, expEbus, expCount);
        assert (fields == 7) else reportFailure("Malformed line in the pattern file");
        records++;
        issueFunc(func, data, expKl, expRst, expRun, expEbus, preCount);
        postStart = pulseTotal;
        repeat (windowCycles) @(posedge masterClk);
        postCount = pulseTotal - postStart;
        if (expRun) begin
          // Free running gives one pulse per rate period
          compareNear("eboxClkEn pulses", expCount, postCount);
          compareNear("eboxClkEn pulses per rate", windowCycles >> rateModel, postCount);
        end else if (wasRunning) begin
          checkValue("eboxClkEn pulses after stop", expCount, postCount);
        end else begin
          checkValue("eboxClkEn pulses", expCount, preCount + postCount);
          if (func == klClkPkg::funcBurst) begin
            checkValue("eboxClkEn burst pulses", burstModel, preCount + postCount);
          end
        end
        wasRunning = expRun;
        repeat (4 + ($urandom % 8)) @(posedge masterClk);
      end
    end
    $fclose(fd);
    assert (records > 0) else reportFailure("No records in the pattern file");
    $display("all tests passed");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
src/klClkPkg.sv
src/crobarSequencer.sv
src/diagFuncDecoder.sv
src/clkControl.sv
src/klClkTop.sv
verification/klClkTb.sv

// File: verification/klClk_patterns.hex
# func ebusData expKlOpcodesEn expEboxReset expRunning expEbusReg expPulses
# Pulses count from the strobe, or over the 64 cycles after it while running
07 000000000 0 1 0 000000000 00
06 000000000 0 0 0 000000000 00
3e 123456789 0 0 0 123456789 00
22 000000005 0 0 0 123456789 00
23 000000000 0 0 0 123456789 00
24 000000009 0 0 0 123456789 00
28 fffffffff 0 0 0 123456789 00
37 000000000 1 0 0 123456789 00
02 000000000 1 0 0 123456789 01
03 000000000 1 0 0 123456789 05
24 00000000e 1 0 0 123456789 00
02 000000000 1 0 0 123456789 01
01 000000000 1 0 1 123456789 08
3e abcdef012 1 0 1 abcdef012 08
00 000000000 1 0 0 abcdef012 00
24 000000000 1 0 0 abcdef012 00
01 000000000 1 0 1 abcdef012 40
00 000000000 1 0 0 abcdef012 00
23 000000001 1 0 0 abcdef012 00
03 000000000 1 0 0 abcdef012 15
